/* hw/rv_pkg.sv */
package rv_pkg;

    // RV32I major opcodes, bits [6:0]
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111
    } opcode_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_ctrl_t;

    typedef enum logic [2:0] {
        BR_NONE,
        BR_EQ,
        BR_NE,
        BR_LT,
        BR_GE,
        BR_LTU,
        BR_GEU,
        BR_ALWAYS
    } br_func_t;

    typedef enum logic [1:0] {
        PC_INC,
        PC_BRANCH,
        PC_JALR
    } pc_source_t;

    // same encoding as load/store funct3
    typedef enum logic [2:0] {
        MEM_BYTE   = 3'b000,
        MEM_HALF   = 3'b001,
        MEM_WORD   = 3'b010,
        MEM_BYTE_U = 3'b100,
        MEM_HALF_U = 3'b101
    } mem_mask_t;

    typedef struct packed {
        logic       valid;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [4:0] rd;
        logic       reg_write;
        logic       mem_to_reg;
        logic       mem_read;
        logic       mem_write;
        mem_mask_t  mem_mask;
        alu_ctrl_t  alu_ctrl;
        logic       alu_pc;
        logic       alu_imm;
        br_func_t   br_func;
        pc_source_t pc_source;
        logic [31:0] pc;
        logic [31:0] rs1_data;
        logic [31:0] rs2_data;
        logic [31:0] imm;
    } id_bundle_t;

    typedef struct packed {
        logic        valid;
        logic [4:0]  rd;
        logic        reg_write;
        logic        mem_to_reg;
        logic        mem_read;
        logic        mem_write;
        mem_mask_t   mem_mask;
        logic [31:0] result;
        logic [31:0] store_data;
    } ex_bundle_t;

    typedef struct packed {
        logic        we;
        logic [4:0]  rd;
        logic [31:0] data;
    } wb_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] target;
    } redirect_t;

endpackage

/* hw/reg_file.sv */
`timescale 1ns/1ps

module reg_file (
    input  logic             clk,
    input  logic             rst_n,
    input  logic [4:0]       rs1_addr,
    input  logic [4:0]       rs2_addr,
    input  rv_pkg::wb_t      wb,
    output logic [31:0]      rs1_data,
    output logic [31:0]      rs2_data
);

    logic [31:0] regs [1:31];
    logic        wr_en;

    // x0 is never stored
    assign wr_en = wb.we && (wb.rd != 5'd0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // write-through so decode sees this cycle's write-back
    always_comb begin
        if (rs1_addr == 5'd0) begin
            rs1_data = '0;
        end else if (wr_en && wb.rd == rs1_addr) begin
            rs1_data = wb.data;
        end else begin
            rs1_data = regs[rs1_addr];
        end
        if (rs2_addr == 5'd0) begin
            rs2_data = '0;
        end else if (wr_en && wb.rd == rs2_addr) begin
            rs2_data = wb.data;
        end else begin
            rs2_data = regs[rs2_addr];
        end
    end

endmodule

/* hw/id_stage.sv */
`timescale 1ns/1ps

module id_stage (
    input  logic               valid,
    input  logic [31:0]        pc,
    input  logic [31:0]        instr,
    input  logic [31:0]        rs1_data,
    input  logic [31:0]        rs2_data,
    output logic [4:0]         rs1_addr,
    output logic [4:0]         rs2_addr,
    output rv_pkg::id_bundle_t bundle
);

    rv_pkg::opcode_t opcode;
    logic [2:0]      funct3;
    logic            alt;
    logic            uses_rs1;
    logic            uses_rs2;
    logic [31:0]     imm_i;
    logic [31:0]     imm_s;
    logic [31:0]     imm_b;
    logic [31:0]     imm_u;
    logic [31:0]     imm_j;

    assign opcode   = rv_pkg::opcode_t'(instr[6:0]);
    assign funct3   = instr[14:12];
    assign rs1_addr = instr[19:15];
    assign rs2_addr = instr[24:20];

    // funct7[5] selects sub/sra, but only srai among the immediates
    assign alt = instr[30] && (opcode == rv_pkg::OP || funct3 == 3'b101);

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        bundle           = '0;
        bundle.valid     = valid;
        bundle.pc        = pc;
        bundle.rs1_data  = rs1_data;
        bundle.rs2_data  = rs2_data;
        bundle.alu_ctrl  = rv_pkg::ALU_ADD;
        bundle.br_func   = rv_pkg::BR_NONE;
        bundle.pc_source = rv_pkg::PC_INC;
        bundle.mem_mask  = rv_pkg::MEM_WORD;
        uses_rs1         = 1'b0;
        uses_rs2         = 1'b0;

        case (opcode)
            rv_pkg::OP, rv_pkg::OP_IMM: begin
                bundle.reg_write = 1'b1;
                bundle.alu_imm   = (opcode == rv_pkg::OP_IMM);
                bundle.imm       = imm_i;
                uses_rs1         = 1'b1;
                uses_rs2         = (opcode == rv_pkg::OP);
                case (funct3)
                    3'b000:  bundle.alu_ctrl = alt ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
                    3'b001:  bundle.alu_ctrl = rv_pkg::ALU_SLL;
                    3'b010:  bundle.alu_ctrl = rv_pkg::ALU_SLT;
                    3'b011:  bundle.alu_ctrl = rv_pkg::ALU_SLTU;
                    3'b100:  bundle.alu_ctrl = rv_pkg::ALU_XOR;
                    3'b101:  bundle.alu_ctrl = alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
                    3'b110:  bundle.alu_ctrl = rv_pkg::ALU_OR;
                    default: bundle.alu_ctrl = rv_pkg::ALU_AND;
                endcase
            end
            rv_pkg::LOAD, rv_pkg::STORE: begin
                bundle.alu_imm    = 1'b1;
                bundle.reg_write  = (opcode == rv_pkg::LOAD);
                bundle.mem_to_reg = (opcode == rv_pkg::LOAD);
                bundle.mem_read   = (opcode == rv_pkg::LOAD);
                bundle.mem_write  = (opcode == rv_pkg::STORE);
                bundle.imm        = (opcode == rv_pkg::LOAD) ? imm_i : imm_s;
                uses_rs1          = 1'b1;
                uses_rs2          = (opcode == rv_pkg::STORE);
                case (funct3)
                    3'b000:  bundle.mem_mask = rv_pkg::MEM_BYTE;
                    3'b001:  bundle.mem_mask = rv_pkg::MEM_HALF;
                    3'b100:  bundle.mem_mask = rv_pkg::MEM_BYTE_U;
                    3'b101:  bundle.mem_mask = rv_pkg::MEM_HALF_U;
                    default: bundle.mem_mask = rv_pkg::MEM_WORD;
                endcase
            end
            rv_pkg::BRANCH: begin
                bundle.pc_source = rv_pkg::PC_BRANCH;
                bundle.imm       = imm_b;
                uses_rs1         = 1'b1;
                uses_rs2         = 1'b1;
                case (funct3)
                    3'b000:  bundle.br_func = rv_pkg::BR_EQ;
                    3'b001:  bundle.br_func = rv_pkg::BR_NE;
                    3'b100:  bundle.br_func = rv_pkg::BR_LT;
                    3'b101:  bundle.br_func = rv_pkg::BR_GE;
                    3'b110:  bundle.br_func = rv_pkg::BR_LTU;
                    3'b111:  bundle.br_func = rv_pkg::BR_GEU;
                    default: bundle.br_func = rv_pkg::BR_NONE;
                endcase
            end
            rv_pkg::JAL: begin
                bundle.reg_write = 1'b1;
                bundle.br_func   = rv_pkg::BR_ALWAYS;
                bundle.pc_source = rv_pkg::PC_BRANCH;
                bundle.imm       = imm_j;
            end
            rv_pkg::JALR: begin
                bundle.reg_write = 1'b1;
                bundle.br_func   = rv_pkg::BR_ALWAYS;
                bundle.pc_source = rv_pkg::PC_JALR;
                bundle.imm       = imm_i;
                uses_rs1         = 1'b1;
            end
            rv_pkg::LUI, rv_pkg::AUIPC: begin
                bundle.reg_write = 1'b1;
                bundle.alu_imm   = 1'b1;
                bundle.alu_pc    = (opcode == rv_pkg::AUIPC);
                bundle.alu_ctrl  = (opcode == rv_pkg::LUI) ? rv_pkg::ALU_PASS_B : rv_pkg::ALU_ADD;
                bundle.imm       = imm_u;
            end
            default: begin
                bundle.imm = imm_i;
            end
        endcase

        // unused or idle fields stay zero so hazard compares see no false match
        bundle.rs1 = (valid && uses_rs1) ? rs1_addr : 5'd0;
        bundle.rs2 = (valid && uses_rs2) ? rs2_addr : 5'd0;
        bundle.rd  = bundle.reg_write ? instr[11:7] : 5'd0;
    end

endmodule

/* hw/hazard_unit.sv */
`timescale 1ns/1ps

module hazard_unit (
    input  logic [4:0] id_rs1,
    input  logic [4:0] id_rs2,
    input  logic       ex_valid,
    input  logic       ex_mem_read,
    input  logic [4:0] ex_rd,
    input  logic       redirect_valid,
    input  logic       freeze,
    output logic       stall,
    output logic       flush,
    output logic       if_hold
);

    logic load_use;

    assign load_use = ex_valid && ex_mem_read && (ex_rd != 5'd0)
                      && (ex_rd == id_rs1 || ex_rd == id_rs2);

    // freeze wins, then redirect, then load-use bubble
    always_comb begin
        stall   = freeze;
        flush   = !freeze && (redirect_valid || load_use);
        if_hold = freeze || (!redirect_valid && load_use);
    end

endmodule

/* hw/id_ex_buffer.sv */
`timescale 1ns/1ps

module id_ex_buffer (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               stall,
    input  logic               flush,
    input  rv_pkg::id_bundle_t id_in,
    output rv_pkg::id_bundle_t ex
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex          <= '0;
            ex.alu_ctrl <= rv_pkg::ALU_ADD;
            ex.br_func  <= rv_pkg::BR_NONE;
            ex.pc_source <= rv_pkg::PC_INC;
            ex.mem_mask <= rv_pkg::MEM_WORD;
        end else if (stall) begin
            ex <= ex;
        end else if (flush) begin
            // bubble; pc and operand data left as they were
            ex.valid      <= 1'b0;
            ex.rs1        <= 5'd0;
            ex.rs2        <= 5'd0;
            ex.rd         <= 5'd0;
            ex.reg_write  <= 1'b0;
            ex.mem_to_reg <= 1'b0;
            ex.mem_read   <= 1'b0;
            ex.mem_write  <= 1'b0;
            ex.mem_mask   <= rv_pkg::MEM_WORD;
            ex.alu_ctrl   <= rv_pkg::ALU_ADD;
            ex.alu_pc     <= 1'b0;
            ex.alu_imm    <= 1'b0;
            ex.br_func    <= rv_pkg::BR_NONE;
            ex.pc_source  <= rv_pkg::PC_INC;
        end else begin
            ex <= id_in;
        end
    end

endmodule

/* hw/ex_stage.sv */
`timescale 1ns/1ps

module ex_stage (
    input  rv_pkg::id_bundle_t ex,
    output rv_pkg::ex_bundle_t ex_out,
    output rv_pkg::redirect_t  redirect
);

    logic [31:0] op_a;
    logic [31:0] op_b;
    logic [31:0] alu_out;
    logic [31:0] link;
    logic        taken;

    assign op_a = ex.alu_pc ? ex.pc : ex.rs1_data;
    assign op_b = ex.alu_imm ? ex.imm : ex.rs2_data;
    assign link = ex.pc + 32'd4;

    always_comb begin
        case (ex.alu_ctrl)
            rv_pkg::ALU_ADD:    alu_out = op_a + op_b;
            rv_pkg::ALU_SUB:    alu_out = op_a - op_b;
            rv_pkg::ALU_SLL:    alu_out = op_a << op_b[4:0];
            rv_pkg::ALU_SLT:    alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
            rv_pkg::ALU_SLTU:   alu_out = {31'b0, op_a < op_b};
            rv_pkg::ALU_XOR:    alu_out = op_a ^ op_b;
            rv_pkg::ALU_SRL:    alu_out = op_a >> op_b[4:0];
            rv_pkg::ALU_SRA:    alu_out = $unsigned($signed(op_a) >>> op_b[4:0]);
            rv_pkg::ALU_OR:     alu_out = op_a | op_b;
            rv_pkg::ALU_AND:    alu_out = op_a & op_b;
            rv_pkg::ALU_PASS_B: alu_out = op_b;
            default:            alu_out = op_a + op_b;
        endcase
    end

    // compare always on the register operands
    always_comb begin
        case (ex.br_func)
            rv_pkg::BR_EQ:     taken = (ex.rs1_data == ex.rs2_data);
            rv_pkg::BR_NE:     taken = (ex.rs1_data != ex.rs2_data);
            rv_pkg::BR_LT:     taken = ($signed(ex.rs1_data) < $signed(ex.rs2_data));
            rv_pkg::BR_GE:     taken = ($signed(ex.rs1_data) >= $signed(ex.rs2_data));
            rv_pkg::BR_LTU:    taken = (ex.rs1_data < ex.rs2_data);
            rv_pkg::BR_GEU:    taken = (ex.rs1_data >= ex.rs2_data);
            rv_pkg::BR_ALWAYS: taken = 1'b1;
            default:           taken = 1'b0;
        endcase
    end

    always_comb begin
        redirect.valid = ex.valid && taken;
        if (ex.pc_source == rv_pkg::PC_JALR) begin
            redirect.target = (ex.rs1_data + ex.imm) & ~32'd1;
        end else begin
            redirect.target = ex.pc + ex.imm;
        end
    end

    always_comb begin
        ex_out.valid      = ex.valid;
        ex_out.rd         = ex.rd;
        ex_out.reg_write  = ex.reg_write;
        ex_out.mem_to_reg = ex.mem_to_reg;
        ex_out.mem_read   = ex.mem_read;
        ex_out.mem_write  = ex.mem_write;
        ex_out.mem_mask   = ex.mem_mask;
        // jumps write the link address
        ex_out.result     = (ex.br_func == rv_pkg::BR_ALWAYS) ? link : alu_out;
        ex_out.store_data = ex.rs2_data;
    end

endmodule

/* hw/id_ex_top.sv */
`timescale 1ns/1ps

module id_ex_top (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               if_valid,
    input  logic [31:0]        if_pc,
    input  logic [31:0]        if_instr,
    input  rv_pkg::wb_t        wb,
    input  logic               freeze,
    output logic               if_hold,
    output rv_pkg::ex_bundle_t ex_out,
    output rv_pkg::redirect_t  redirect
);

    logic [4:0]         rs1_addr;
    logic [4:0]         rs2_addr;
    logic [31:0]        rs1_data;
    logic [31:0]        rs2_data;
    logic               stall;
    logic               flush;
    rv_pkg::id_bundle_t id_bundle;
    rv_pkg::id_bundle_t ex_bundle;

    reg_file u_reg_file (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .wb       (wb),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    id_stage u_id_stage (
        .valid    (if_valid),
        .pc       (if_pc),
        .instr    (if_instr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .bundle   (id_bundle)
    );

    hazard_unit u_hazard_unit (
        .id_rs1         (id_bundle.rs1),
        .id_rs2         (id_bundle.rs2),
        .ex_valid       (ex_bundle.valid),
        .ex_mem_read    (ex_bundle.mem_read),
        .ex_rd          (ex_bundle.rd),
        .redirect_valid (redirect.valid),
        .freeze         (freeze),
        .stall          (stall),
        .flush          (flush),
        .if_hold        (if_hold)
    );

    id_ex_buffer u_id_ex_buffer (
        .clk   (clk),
        .rst_n (rst_n),
        .stall (stall),
        .flush (flush),
        .id_in (id_bundle),
        .ex    (ex_bundle)
    );

    ex_stage u_ex_stage (
        .ex       (ex_bundle),
        .ex_out   (ex_out),
        .redirect (redirect)
    );

endmodule

/* sim/tb_id_ex_top.sv */
`timescale 1ns/1ps

module tb_id_ex_top;

    // one predicted execute slot
    typedef struct packed {
        logic        valid;
        logic        load;
        logic [4:0]  rd;
        logic        reg_write;
        logic        mem_read;
        logic        mem_write;
        logic [2:0]  mask;
        logic [31:0] result;
        logic [31:0] store_data;
        logic        redir;
        logic [31:0] target;
        logic [4:0]  use1;
        logic [4:0]  use2;
    } slot_t;

    localparam int PROG_LEN   = 37;
    localparam int MAX_CYCLES = 300;

    localparam logic [6:0] OP_R      = 7'h33;
    localparam logic [6:0] OP_I      = 7'h13;
    localparam logic [6:0] OP_LOAD   = 7'h03;
    localparam logic [6:0] OP_STORE  = 7'h23;
    localparam logic [6:0] OP_BRANCH = 7'h63;
    localparam logic [6:0] OP_JAL    = 7'h6f;
    localparam logic [6:0] OP_JALR   = 7'h67;
    localparam logic [6:0] OP_LUI    = 7'h37;
    localparam logic [6:0] OP_AUIPC  = 7'h17;

    logic               clk;
    logic               rst_n;
    logic               if_valid;
    logic [31:0]        if_pc;
    logic [31:0]        if_instr;
    rv_pkg::wb_t        wb;
    logic               freeze;
    logic               if_hold;
    rv_pkg::ex_bundle_t ex_out;
    rv_pkg::redirect_t  redirect;

    logic [31:0] prog [0:63];
    logic [31:0] ref_regs [0:31];
    slot_t       exp_slot;
    slot_t       id_slot;
    logic        exp_hold;
    logic [31:0] pc;
    integer      seed;
    int          cycle;
    int          errors;
    int          bubbles;
    int          redirects;

    id_ex_top u_id_ex_top (
        .clk      (clk),
        .rst_n    (rst_n),
        .if_valid (if_valid),
        .if_pc    (if_pc),
        .if_instr (if_instr),
        .wb       (wb),
        .freeze   (freeze),
        .if_hold  (if_hold),
        .ex_out   (ex_out),
        .redirect (redirect)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] enc_r(input int f7, input int rs2, input int rs1,
                                          input int f3, input int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OP_R};
    endfunction

    function automatic logic [31:0] enc_i(input int imm, input int rs1, input int f3,
                                          input int rd, input logic [6:0] op);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
    endfunction

    function automatic logic [31:0] enc_s(input int imm, input int rs2, input int rs1,
                                          input int f3);
        return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], OP_STORE};
    endfunction

    function automatic logic [31:0] enc_b(input int imm, input int rs2, input int rs1,
                                          input int f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], OP_BRANCH};
    endfunction

    function automatic logic [31:0] enc_u(input int imm, input int rd, input logic [6:0] op);
        return {imm[19:0], rd[4:0], op};
    endfunction

    function automatic logic [31:0] enc_j(input int imm, input int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], OP_JAL};
    endfunction

    function automatic logic [31:0] alu_ref(input logic [31:0] a, input logic [31:0] b,
                                            input logic [2:0] f3, input logic alt);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    return (a < b) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd5:    return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_taken(input logic [31:0] a, input logic [31:0] b,
                                          input logic [2:0] f3);
        case (f3)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return $signed(a) < $signed(b);
            3'd5:    return $signed(a) >= $signed(b);
            3'd6:    return a < b;
            3'd7:    return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    // what the instruction in decode should produce one cycle later
    function automatic slot_t predict(input logic valid, input logic [31:0] instr,
                                      input logic [31:0] pc_in);
        slot_t       s;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] imm_u;
        logic [2:0]  f3;
        f3      = instr[14:12];
        a       = ref_regs[instr[19:15]];
        b       = ref_regs[instr[24:20]];
        imm_i   = {{20{instr[31]}}, instr[31:20]};
        imm_u   = {instr[31:12], 12'b0};
        s       = '0;
        s.valid = valid;
        s.mask  = f3;
        case (instr[6:0])
            OP_R, OP_I: begin
                s.reg_write = 1'b1;
                s.use1      = instr[19:15];
                if (instr[6:0] == OP_R) begin
                    s.use2   = instr[24:20];
                    s.result = alu_ref(a, b, f3, instr[30]);
                end else begin
                    s.result = alu_ref(a, imm_i, f3, instr[30] && f3 == 3'd5);
                end
            end
            OP_LOAD: begin
                s.load      = 1'b1;
                s.reg_write = 1'b1;
                s.mem_read  = 1'b1;
                s.result    = a + imm_i;
                s.use1      = instr[19:15];
            end
            OP_STORE: begin
                s.mem_write  = 1'b1;
                s.result     = a + {{20{instr[31]}}, instr[31:25], instr[11:7]};
                s.store_data = b;
                s.use1       = instr[19:15];
                s.use2       = instr[24:20];
            end
            OP_BRANCH: begin
                s.redir  = branch_taken(a, b, f3);
                s.target = pc_in + {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
                s.use1   = instr[19:15];
                s.use2   = instr[24:20];
            end
            OP_JAL: begin
                s.reg_write = 1'b1;
                s.result    = pc_in + 32'd4;
                s.redir     = 1'b1;
                s.target    = pc_in + {{12{instr[31]}}, instr[19:12], instr[20],
                                       instr[30:21], 1'b0};
            end
            OP_JALR: begin
                s.reg_write = 1'b1;
                s.result    = pc_in + 32'd4;
                s.redir     = 1'b1;
                s.target    = (a + imm_i) & ~32'd1;
                s.use1      = instr[19:15];
            end
            OP_LUI: begin
                s.reg_write = 1'b1;
                s.result    = imm_u;
            end
            OP_AUIPC: begin
                s.reg_write = 1'b1;
                s.result    = pc_in + imm_u;
            end
            default: begin
                s.reg_write = 1'b0;
            end
        endcase
        s.redir = s.redir && valid;
        if (s.reg_write) begin
            s.rd = instr[11:7];
        end
        return s;
    endfunction

    function automatic logic load_use_match(input slot_t ex, input slot_t id);
        return ex.valid && ex.load && ex.rd != 5'd0 && id.valid
               && (ex.rd == id.use1 || ex.rd == id.use2);
    endfunction

    task automatic load_program();
        // filler past the program is addi x0, x0, index
        for (int i = 0; i < 64; i++) begin
            prog[i] = enc_i(i, 0, 0, 0, OP_I);
        end
        prog[0]  = enc_i(100, 0, 0, 1, OP_I);
        prog[1]  = enc_i(-7, 0, 0, 2, OP_I);
        prog[2]  = enc_u('h12345, 3, OP_LUI);
        prog[3]  = enc_u(1, 4, OP_AUIPC);
        prog[4]  = enc_i(141, 0, 0, 24, OP_I);
        prog[5]  = enc_r(0, 2, 1, 0, 5);
        prog[6]  = enc_r(32, 2, 1, 0, 6);
        prog[7]  = enc_r(0, 1, 2, 2, 7);
        prog[8]  = enc_r(0, 1, 2, 3, 8);
        prog[9]  = enc_r(0, 3, 1, 4, 9);
        prog[10] = enc_r(0, 1, 1, 1, 10);
        prog[11] = enc_r(32, 1, 2, 5, 11);
        prog[12] = enc_r(0, 1, 2, 5, 12);
        prog[13] = enc_r(0, 2, 3, 6, 13);
        prog[14] = enc_r(0, 1, 3, 7, 14);
        prog[15] = enc_i(-3, 2, 2, 15, OP_I);
        prog[16] = enc_i(-1, 3, 4, 16, OP_I);
        prog[17] = enc_i('h401, 2, 5, 17, OP_I);
        prog[18] = enc_i('h7f0, 3, 7, 18, OP_I);
        prog[19] = enc_s(8, 5, 1, 2);
        // load-use pairs on rs1 then rs2
        prog[20] = enc_i(4, 1, 2, 19, OP_LOAD);
        prog[21] = enc_r(0, 1, 19, 0, 20);
        prog[22] = enc_i(-1, 1, 4, 21, OP_LOAD);
        prog[23] = enc_r(32, 21, 1, 0, 25);
        prog[24] = enc_s(2, 2, 1, 1);
        prog[25] = enc_b(8, 1, 1, 0);
        prog[26] = enc_i(1, 0, 0, 26, OP_I);
        prog[27] = enc_b(8, 1, 1, 1);
        prog[28] = enc_b(8, 1, 2, 4);
        prog[29] = enc_i(2, 0, 0, 26, OP_I);
        prog[30] = enc_j(8, 27);
        prog[31] = enc_i(3, 0, 0, 26, OP_I);
        // x24 holds 141 so the target is 140
        prog[32] = enc_i(0, 24, 0, 28, OP_JALR);
        prog[33] = enc_i(4, 0, 0, 26, OP_I);
        prog[34] = enc_i(5, 0, 0, 26, OP_I);
        prog[35] = enc_r(0, 28, 27, 0, 29);
        prog[36] = enc_i(1, 27, 0, 30, OP_I);
    endtask

    // runs 2 ns after each edge to retire, fetch and drive the next cycle
    task automatic advance_cycle();
        slot_t       next_slot;
        rv_pkg::wb_t wb_next;
        logic        load_use;
        load_use  = load_use_match(exp_slot, id_slot);
        next_slot = '0;
        wb_next   = '0;
        if (!freeze && exp_slot.valid && exp_slot.reg_write) begin
            wb_next.we   = 1'b1;
            wb_next.rd   = exp_slot.rd;
            wb_next.data = exp_slot.load ? $random(seed) : exp_slot.result;
        end
        if (freeze) begin
            next_slot = exp_slot;
        end else if (exp_slot.redir) begin
            pc = exp_slot.target;
            redirects++;
        end else if (load_use) begin
            bubbles++;
        end else if (if_valid) begin
            next_slot = id_slot;
            pc        = pc + 32'd4;
        end
        exp_slot = next_slot;
        cycle++;
        freeze = (cycle >= 12 && cycle < 16);
        wb     = wb_next;
        if (wb_next.we && wb_next.rd != 5'd0) begin
            ref_regs[wb_next.rd] = wb_next.data;
        end
        if_valid = (cycle >= 3);
        if_pc    = pc;
        if_instr = if_valid ? prog[pc[7:2]] : 32'd0;
        id_slot  = predict(if_valid, if_instr, if_pc);
        exp_hold = freeze || (!exp_slot.redir && load_use_match(exp_slot, id_slot));
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        errors++;
        $display("** Error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
    endtask

    assert property (@(posedge clk) disable iff (!rst_n) ex_out.valid == exp_slot.valid)
        else report_mismatch("ex_out.valid", 32'($sampled(exp_slot.valid)),
                             32'($sampled(ex_out.valid)));
    assert property (@(posedge clk) disable iff (!rst_n) ex_out.reg_write == exp_slot.reg_write)
        else report_mismatch("ex_out.reg_write", 32'($sampled(exp_slot.reg_write)),
                             32'($sampled(ex_out.reg_write)));
    assert property (@(posedge clk) disable iff (!rst_n) ex_out.mem_to_reg == exp_slot.load)
        else report_mismatch("ex_out.mem_to_reg", 32'($sampled(exp_slot.load)),
                             32'($sampled(ex_out.mem_to_reg)));
    assert property (@(posedge clk) disable iff (!rst_n) ex_out.mem_read == exp_slot.mem_read)
        else report_mismatch("ex_out.mem_read", 32'($sampled(exp_slot.mem_read)),
                             32'($sampled(ex_out.mem_read)));
    assert property (@(posedge clk) disable iff (!rst_n) ex_out.mem_write == exp_slot.mem_write)
        else report_mismatch("ex_out.mem_write", 32'($sampled(exp_slot.mem_write)),
                             32'($sampled(ex_out.mem_write)));
    assert property (@(posedge clk) disable iff (!rst_n)
        exp_slot.valid && exp_slot.reg_write |-> ex_out.rd == exp_slot.rd)
        else report_mismatch("ex_out.rd", 32'($sampled(exp_slot.rd)),
                             32'($sampled(ex_out.rd)));
    assert property (@(posedge clk) disable iff (!rst_n)
        exp_slot.valid && (exp_slot.reg_write || exp_slot.mem_read || exp_slot.mem_write)
        |-> ex_out.result == exp_slot.result)
        else report_mismatch("ex_out.result", $sampled(exp_slot.result),
                             $sampled(ex_out.result));
    assert property (@(posedge clk) disable iff (!rst_n)
        exp_slot.mem_write |-> ex_out.store_data == exp_slot.store_data)
        else report_mismatch("ex_out.store_data", $sampled(exp_slot.store_data),
                             $sampled(ex_out.store_data));
    assert property (@(posedge clk) disable iff (!rst_n)
        exp_slot.mem_read || exp_slot.mem_write |-> ex_out.mem_mask == exp_slot.mask)
        else report_mismatch("ex_out.mem_mask", 32'($sampled(exp_slot.mask)),
                             32'($sampled(ex_out.mem_mask)));
    assert property (@(posedge clk) disable iff (!rst_n) redirect.valid == exp_slot.redir)
        else report_mismatch("redirect.valid", 32'($sampled(exp_slot.redir)),
                             32'($sampled(redirect.valid)));
    assert property (@(posedge clk) disable iff (!rst_n)
        exp_slot.redir |-> redirect.target == exp_slot.target)
        else report_mismatch("redirect.target", $sampled(exp_slot.target),
                             $sampled(redirect.target));
    assert property (@(posedge clk) disable iff (!rst_n) if_hold == exp_hold)
        else report_mismatch("if_hold", 32'($sampled(exp_hold)), 32'($sampled(if_hold)));
    // buffer held at the last edge, so execute must not move
    assert property (@(posedge clk) disable iff (!rst_n) $past(freeze) |-> $stable(ex_out))
        else begin
            errors++;
            $display("ex_out changed during a freeze at %0t ns", $time);
        end

    initial begin
        seed      = 44578;
        errors    = 0;
        bubbles   = 0;
        redirects = 0;
        cycle     = 0;
        rst_n     = 1'b0;
        if_valid  = 1'b0;
        if_pc     = '0;
        if_instr  = '0;
        wb        = '0;
        freeze    = 1'b0;
        pc        = '0;
        exp_slot  = '0;
        id_slot   = '0;
        exp_hold  = 1'b0;
        for (int i = 0; i < 32; i++) begin
            ref_regs[i] = '0;
        end
        load_program();
        repeat (3) @(posedge clk);
        #2;
        rst_n = 1'b1;
        while (pc < 4 * (PROG_LEN + 1) && cycle < MAX_CYCLES) begin
            @(posedge clk);
            #2;
            advance_cycle();
        end
        if (cycle >= MAX_CYCLES) begin
            errors++;
            $display("timeout: fetch never got past the program after %0d cycles", cycle);
        end
        // drain the last instructions through execute
        for (int i = 0; i < 4; i++) begin
            @(posedge clk);
            #2;
            advance_cycle();
        end
        if (bubbles != 2 || redirects != 4) begin
            errors++;
            $display("stimulus missed hazards: %0d load-use bubbles, %0d redirects",
                     bubbles, redirects);
        end
        $display("checks finished with %0d errors", errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* verilog.f */
hw/rv_pkg.sv
hw/reg_file.sv
hw/id_stage.sv
hw/hazard_unit.sv
hw/id_ex_buffer.sv
hw/ex_stage.sv
hw/id_ex_top.sv
sim/tb_id_ex_top.sv
